// ==== Bender.yml ====
package:
  name: vec_stream

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/vec_pkg.sv
      - logic/stream_fifo.sv
      - logic/vec_add_stream.sv
      - logic/vec_stream_top.sv
  - target: test
    files:
      - tb/vec_stream_tb.sv

// ==== list.f ====
+incdir+logic
logic/vec_pkg.sv
logic/stream_fifo.sv
logic/vec_add_stream.sv
logic/vec_stream_top.sv
tb/vec_stream_tb.sv

// ==== logic/stream_fifo.sv ====
`timescale 1ns/1ps

module stream_fifo #(
  parameter int DATA_WIDTH   = 16,
  parameter int DEPTH        = 8,
  parameter int AF_THRESHOLD = DEPTH - 2
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wr_en,
  input  logic                  rd_en,
  input  logic [DATA_WIDTH-1:0] wr_data,
  output logic [DATA_WIDTH-1:0] rd_data,
  output logic                  full,
  output logic                  almost_full,
  output logic                  empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [DATA_WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [CNT_W-1:0]      count;
  logic                  do_wr;
  logic                  do_rd;

  // Wrap at DEPTH so non power of two depths work too
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign do_wr = wr_en && !full;   // Drop writes when full
  assign do_rd = rd_en && !empty;  // Drop reads when empty

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_rd) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Idle or write with read
      endcase
    end
  end

  assign rd_data     = mem[rd_ptr];  // First word fall through
  assign full        = (count == CNT_W'(DEPTH));
  assign almost_full = (count >= CNT_W'(AF_THRESHOLD));
  assign empty       = (count == '0);

  // Producers and consumers must honor the flags
  a_no_overflow: assert property (
    @(posedge clk) disable iff (!rst_n) !(wr_en && full)
  ) else $error("stream_fifo: write while full");

  a_no_underflow: assert property (
    @(posedge clk) disable iff (!rst_n) !(rd_en && empty)
  ) else $error("stream_fifo: read while empty");

endmodule

// ==== logic/vec_add_stream.sv ====
`timescale 1ns/1ps
`include "vec_defines.svh"

module vec_add_stream (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in1_en,
  input  vec_pkg::vec_data_t in1_data,
  output logic               in1_full,
  input  logic               in2_en,
  input  vec_pkg::vec_data_t in2_data,
  output logic               in2_full,
  input  logic               out_en,
  output vec_pkg::vec_data_t out_data,
  output logic               out_empty,
  input  vec_pkg::vec_len_t  vector_length,
  input  logic               start,
  output logic               idle,
  output logic               ready,
  output logic               done
);

  localparam int AF_LEVEL = `VEC_FIFO_DEPTH - `VEC_AF_MARGIN;

  vec_pkg::vec_state_t state;
  vec_pkg::vec_state_t state_nxt;
  vec_pkg::vec_len_t   len_q;      // Latched job length
  vec_pkg::vec_len_t   processed;  // Pairs popped so far

  vec_pkg::vec_data_t  op1;
  vec_pkg::vec_data_t  op2;
  vec_pkg::vec_data_t  sum_q;
  logic                sum_valid;  // Registered pop strobe

  logic                in1_empty;
  logic                in2_empty;
  logic                out_full;
  logic                out_af;
  logic                in1_wr;
  logic                in2_wr;
  logic                pop;
  logic                out_rd;

  // Operands only accepted while a job runs
  assign in1_wr = (state == vec_pkg::COMPUTE) && in1_en && !in1_full;
  assign in2_wr = (state == vec_pkg::COMPUTE) && in2_en && !in2_full;

  // Pop a pair when both heads are valid and the output has room
  assign pop = (state == vec_pkg::COMPUTE) && !in1_empty && !in2_empty &&
               !out_af && (processed != len_q);

  assign out_rd = (state != vec_pkg::IDLE) && out_en && !out_empty;

  always_comb begin
    state_nxt = state;
    case (state)
      vec_pkg::IDLE: begin
        if (start) begin
          // Empty job skips the compute phase
          state_nxt = (vector_length == '0) ? vec_pkg::DONE : vec_pkg::COMPUTE;
        end
      end
      vec_pkg::COMPUTE: begin
        if (processed == len_q) begin
          state_nxt = vec_pkg::DONE;
        end
      end
      vec_pkg::DONE: begin
        if (out_empty) begin
          state_nxt = vec_pkg::IDLE;  // Sink has drained every sum
        end
      end
      default: state_nxt = vec_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= vec_pkg::IDLE;
      len_q     <= '0;
      processed <= '0;
    end else begin
      state <= state_nxt;
      if ((state == vec_pkg::IDLE) && start) begin
        len_q     <= vector_length;
        processed <= '0;
      end else if (pop) begin
        processed <= processed + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      sum_q <= op1 + op2;  // Wraps at data width
    end
  end

  assign idle  = (state == vec_pkg::IDLE);
  assign ready = (state == vec_pkg::COMPUTE);
  assign done  = (state == vec_pkg::DONE);

  stream_fifo #(
    .DATA_WIDTH (`VEC_DATA_WIDTH),
    .DEPTH      (`VEC_FIFO_DEPTH)
  ) in1_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_en       (in1_wr),
    .rd_en       (pop),
    .wr_data     (in1_data),
    .rd_data     (op1),
    .full        (in1_full),
    .almost_full (),
    .empty       (in1_empty)
  );

  stream_fifo #(
    .DATA_WIDTH (`VEC_DATA_WIDTH),
    .DEPTH      (`VEC_FIFO_DEPTH)
  ) in2_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_en       (in2_wr),
    .rd_en       (pop),
    .wr_data     (in2_data),
    .rd_data     (op2),
    .full        (in2_full),
    .almost_full (),
    .empty       (in2_empty)
  );

  stream_fifo #(
    .DATA_WIDTH   (`VEC_DATA_WIDTH),
    .DEPTH        (`VEC_FIFO_DEPTH),
    .AF_THRESHOLD (AF_LEVEL)  // Leaves slots for sums in flight
  ) out_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_en       (sum_valid),
    .rd_en       (out_rd),
    .wr_data     (sum_q),
    .rd_data     (out_data),
    .full        (out_full),
    .almost_full (out_af),
    .empty       (out_empty)
  );

  a_count_bound: assert property (
    @(posedge clk) disable iff (!rst_n) processed <= len_q
  ) else $error("vec_add_stream: processed count beyond job length");

  // Almost-full margin must cover the pipeline
  a_out_margin: assert property (
    @(posedge clk) disable iff (!rst_n) sum_valid |-> !out_full
  ) else $error("vec_add_stream: sum written into full output FIFO");

endmodule

// ==== logic/vec_defines.svh ====
`ifndef VEC_DEFINES_SVH
`define VEC_DEFINES_SVH

// Element width in bits
`define VEC_DATA_WIDTH  16

// Vector length and pair counter width
`define VEC_LENGTH_BITS 10

// Entries per stream FIFO
`define VEC_FIFO_DEPTH  8

// Room kept in the output FIFO for sums still in the pipeline
`define VEC_AF_MARGIN   2

`endif

// ==== logic/vec_pkg.sv ====
`include "vec_defines.svh"

package vec_pkg;

  // One stream element
  typedef logic [`VEC_DATA_WIDTH-1:0] vec_data_t;

  // Vector length or element count
  typedef logic [`VEC_LENGTH_BITS-1:0] vec_len_t;

  // Job controller states
  typedef enum logic [1:0] {
    IDLE    = 2'b00,
    COMPUTE = 2'b01,
    DONE    = 2'b10
  } vec_state_t;

endpackage

// ==== logic/vec_stream_top.sv ====
`timescale 1ns/1ps

module vec_stream_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in1_en,
  input  vec_pkg::vec_data_t in1_data,
  output logic               in1_full,
  input  logic               in2_en,
  input  vec_pkg::vec_data_t in2_data,
  output logic               in2_full,
  input  logic               out_en,
  output vec_pkg::vec_data_t out_data,
  output logic               out_empty,
  input  vec_pkg::vec_len_t  vector_length,
  input  logic               start,
  output logic               idle,
  output logic               ready,
  output logic               done
);

  // Adder subsystem with its three stream FIFOs
  vec_add_stream u_vec_add (
    .clk           (clk),
    .rst_n         (rst_n),
    .in1_en        (in1_en),
    .in1_data      (in1_data),
    .in1_full      (in1_full),
    .in2_en        (in2_en),
    .in2_data      (in2_data),
    .in2_full      (in2_full),
    .out_en        (out_en),
    .out_data      (out_data),
    .out_empty     (out_empty),
    .vector_length (vector_length),
    .start         (start),
    .idle          (idle),
    .ready         (ready),
    .done          (done)
  );

endmodule

// ==== tb/vec_stream_tb.sv ====
`timescale 1ns/1ps

module vec_stream_tb;

  localparam int NUM_JOBS = 5;
  localparam int MAX_LEN  = 32;

  logic               clk;
  logic               rst_n;
  logic               in1_en;
  vec_pkg::vec_data_t in1_data;
  logic               in1_full;
  logic               in2_en;
  vec_pkg::vec_data_t in2_data;
  logic               in2_full;
  logic               out_en;
  vec_pkg::vec_data_t out_data;
  logic               out_empty;
  vec_pkg::vec_len_t  vector_length;
  logic               start;
  logic               idle;
  logic               ready;
  logic               done;

  // One array per job table column
  int                 job_len     [NUM_JOBS];
  int                 job_stall   [NUM_JOBS];  // Sink stall percent
  int                 job_pct1    [NUM_JOBS];  // in1 write percent
  int                 job_pct2    [NUM_JOBS];  // in2 write percent
  int                 job_idle_wr [NUM_JOBS];  // Junk writes before start
  logic               job_full    [NUM_JOBS];  // in1_full must be seen
  string              job_name    [NUM_JOBS];
  vec_pkg::vec_data_t op_a        [NUM_JOBS][MAX_LEN];
  vec_pkg::vec_data_t op_b        [NUM_JOBS][MAX_LEN];

  integer             seed;
  int                 pass_count;
  int                 fail_count;
  int                 cycles;
  int                 limit;
  logic               saw_full;

  vec_stream_top UUT (
    .clk (clk), .rst_n (rst_n),
    .in1_en (in1_en), .in1_data (in1_data), .in1_full (in1_full),
    .in2_en (in2_en), .in2_data (in2_data), .in2_full (in2_full),
    .out_en (out_en), .out_data (out_data), .out_empty (out_empty),
    .vector_length (vector_length), .start (start),
    .idle (idle), .ready (ready), .done (done)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic check_data(input vec_pkg::vec_data_t got, input vec_pkg::vec_data_t exp,
                            input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic check_count(input vec_pkg::vec_len_t got, input vec_pkg::vec_len_t exp,
                             input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s got %0d expected %0d", $time, what, got, exp);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s got %b expected %b", $time, what, got, exp);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic add_job(input int j, input string name, input int len, input int stall,
                         input int pct1, input int pct2, input int idle_wr, input logic full);
    job_name[j]    = name;
    job_len[j]     = len;
    job_stall[j]   = stall;
    job_pct1[j]    = pct1;
    job_pct2[j]    = pct2;
    job_idle_wr[j] = idle_wr;
    job_full[j]    = full;
    for (int i = 0; i < MAX_LEN; i++) begin
      op_a[j][i] = vec_pkg::vec_data_t'($random(seed));
      op_b[j][i] = vec_pkg::vec_data_t'($random(seed));
    end
  endtask

  task automatic drive_lane(input int lane, input logic en, input vec_pkg::vec_data_t d);
    if (lane == 1) begin
      in1_en   = en;
      in1_data = d;
    end else begin
      in2_en   = en;
      in2_data = d;
    end
  endtask

  // Holds back a write while the lane is full and resends it later
  task automatic feed_stream(input int j, input int lane);
    int   sent;
    int   pct;
    logic full_now;
    sent = 0;
    pct  = (lane == 1) ? job_pct1[j] : job_pct2[j];
    while (sent < job_len[j]) begin
      full_now = (lane == 1) ? in1_full : in2_full;
      if (full_now && lane == 1) saw_full = 1'b1;
      if (!full_now && ({$random(seed)} % 100) < pct) begin
        drive_lane(lane, 1'b1, (lane == 1) ? op_a[j][sent] : op_b[j][sent]);
        sent++;
      end else begin
        drive_lane(lane, 1'b0, '0);
      end
      @(negedge clk);
    end
    drive_lane(lane, 1'b0, '0);
  endtask

  // Pops the head at a falling edge; the pop lands on the next rising edge
  task automatic drain_outputs(input int j);
    int                 received;
    logic               done_seen;
    vec_pkg::vec_data_t exp;
    received  = 0;
    done_seen = 1'b0;
    while (!idle) begin
      if (done) done_seen = 1'b1;
      if (done && out_empty) begin
        check_count(vec_pkg::vec_len_t'(received), vec_pkg::vec_len_t'(job_len[j]),
                    "outputs taken when done with empty FIFO");
      end
      if (done_seen && !out_empty) check_flag(done, 1'b1, "done held while outputs remain");
      if (!out_empty && ({$random(seed)} % 100) >= job_stall[j]) begin
        if (received < job_len[j]) begin
          exp = op_a[j][received] + op_b[j][received];  // Wrapped 16-bit sum
          check_data(out_data, exp, "sum");
        end else begin
          $display("Extra output %h appeared beyond the job length", out_data);
          fail_count++;
        end
        received++;
        out_en = 1'b1;
      end else begin
        out_en = 1'b0;
      end
      @(negedge clk);
    end
    out_en = 1'b0;
    check_flag(done_seen, 1'b1, "done raised during job");
    check_count(vec_pkg::vec_len_t'(received), vec_pkg::vec_len_t'(job_len[j]), "output count");
  endtask

  task automatic run_job(input int j);
    for (int k = 0; k < job_idle_wr[j]; k++) begin
      @(negedge clk);
      drive_lane(1, 1'b1, vec_pkg::vec_data_t'(16'hdead ^ k));  // Dropped while idle
      drive_lane(2, 1'b1, vec_pkg::vec_data_t'(16'hbeef ^ k));
    end
    @(negedge clk);
    drive_lane(1, 1'b0, '0);
    drive_lane(2, 1'b0, '0);
    vector_length = vec_pkg::vec_len_t'(job_len[j]);
    start         = 1'b1;
    @(negedge clk);
    start    = 1'b0;
    saw_full = 1'b0;
    check_flag(ready, job_len[j] != 0, "ready after start");
    fork
      feed_stream(j, 1);
      feed_stream(j, 2);
      drain_outputs(j);
    join
    check_flag(done, 1'b0, "done after drain");
    check_flag(idle, 1'b1, "idle after drain");
    check_flag(out_empty, 1'b1, "out_empty after drain");
    if (job_full[j]) check_flag(saw_full, 1'b1, "in1_full under back-pressure");
  endtask

  initial begin
    int total;
    int fails_before;
    seed          = 32'hcaf2;
    pass_count    = 0;
    fail_count    = 0;
    cycles        = 0;
    limit         = 0;
    rst_n         = 1'b0;
    in1_en        = 1'b0;
    in1_data      = '0;
    in2_en        = 1'b0;
    in2_data      = '0;
    out_en        = 1'b0;
    vector_length = '0;
    start         = 1'b0;
    saw_full      = 1'b0;

    add_job(0, "length 8 continuous sink", 8, 0, 100, 100, 0, 1'b0);
    add_job(1, "skewed operand writes", 12, 10, 40, 90, 0, 1'b0);
    add_job(2, "long sink stalls", 30, 90, 100, 100, 0, 1'b1);
    add_job(3, "length 0 job", 0, 0, 100, 100, 0, 1'b0);
    add_job(4, "writes while idle dropped", 6, 20, 100, 100, 4, 1'b0);
    op_a[0][0] = 16'hffff;  // Overflow corner cases
    op_b[0][0] = 16'h0001;
    op_a[0][1] = 16'h8000;
    op_b[0][1] = 16'h8000;
    op_a[0][2] = 16'hfffe;
    op_b[0][2] = 16'hffff;

    total = 0;
    for (int j = 0; j < NUM_JOBS; j++) total += job_len[j];
    limit = 20 * total + 400;

    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    fails_before = fail_count;
    check_flag(idle, 1'b1, "idle after reset");
    check_flag(ready, 1'b0, "ready after reset");
    check_flag(done, 1'b0, "done after reset");
    check_flag(out_empty, 1'b1, "out_empty after reset");
    check_flag(in1_full, 1'b0, "in1_full after reset");
    check_flag(in2_full, 1'b0, "in2_full after reset");
    $display("Test 0 reset state: %s", (fail_count == fails_before) ? "PASS" : "FAIL");

    for (int j = 0; j < NUM_JOBS; j++) begin
      fails_before = fail_count;
      run_job(j);
      $display("Test %0d %s: %s", j + 1, job_name[j],
               (fail_count == fails_before) ? "PASS" : "FAIL");
    end

    $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
